// ==== compile.f ====
+incdir+include
hdl/fau_pkg.sv
hdl/fau_ifs.sv
hdl/fau_mont_mult.sv
hdl/fau_add_sub_mod.sv
hdl/fau_top.sv
test/fau_sva.sv
test/fau_tb.sv

// ==== hdl/fau_add_sub_mod.sv ====
/* Modular adder/subtractor
   opa +/- opb, reduced mod prime or wrapping, result registered */

`timescale 1ns/1ps
`include "fau_consts.svh"

module fau_add_sub_mod #(
    parameter int REG_SIZE = `FAU_REG_SIZE
) (
    input logic        clk,
    input logic        reset_i,
    fau_addsub_if.unit addsub
);

    // Raw result with carry (add) or borrow (sub) on top
    logic [REG_SIZE:0]   raw;
    logic                carry;
    logic [REG_SIZE-1:0] raw_lo;
    logic [REG_SIZE-1:0] corr;
    logic                use_corr;
    logic [REG_SIZE-1:0] sel;
    logic [REG_SIZE-1:0] res_q;

    // ----------------------------------------
    // Raw sum or difference
    // ----------------------------------------

    always_comb begin
        if (addsub.sub) begin
            raw = {1'b0, addsub.opa} - {1'b0, addsub.opb};
        end else begin
            raw = {1'b0, addsub.opa} + {1'b0, addsub.opb};
        end
    end

    assign carry  = raw[REG_SIZE];
    assign raw_lo = raw[REG_SIZE-1:0];

    // ----------------------------------------
    // Correction by prime
    // ----------------------------------------

    // Sub: add prime back, wrap cancels the borrow
    // Add: remove prime, wrap cancels the carry
    assign corr = addsub.sub ? (raw_lo + addsub.prime) : (raw_lo - addsub.prime);

    // Sub corrects on borrow
    // Add corrects when the full sum is not below prime
    always_comb begin
        if (addsub.sub) begin
            use_corr = carry;
        end else begin
            use_corr = carry | (raw_lo >= addsub.prime);
        end
    end

    // Without reduction the plain wrapping value goes out
    assign sel = (addsub.red && use_corr) ? corr : raw_lo;

    // Result register, updated every cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            res_q <= '0;
        end else begin
            res_q <= sel;
        end
    end

    assign addsub.res = res_q;

endmodule

// ==== hdl/fau_ifs.sv ====
/* Field arithmetic unit internal buses
   Montgomery multiplier bus and modular adder/subtractor bus */

`timescale 1ns/1ps

// Multiplier bus, start is a one-cycle pulse taken only while ready
interface fau_mult_if;
    logic              start;
    fau_pkg::operand_t opa;
    fau_pkg::operand_t opb;
    fau_pkg::operand_t prime;
    fau_pkg::digit_t   mu;
    fau_pkg::operand_t res;
    logic              ready;

    modport ctrl (output start, opa, opb, prime, mu, input res, ready);
    modport unit (input start, opa, opb, prime, mu, output res, ready);
endinterface

// Adder/subtractor bus, no handshake
// Result follows the inputs one cycle later
interface fau_addsub_if;
    logic              sub;
    logic              red;
    fau_pkg::operand_t opa;
    fau_pkg::operand_t opb;
    fau_pkg::operand_t prime;
    fau_pkg::operand_t res;

    modport ctrl (output sub, red, opa, opb, prime, input res);
    modport unit (input sub, red, opa, opb, prime, output res);
endinterface

// ==== hdl/fau_mont_mult.sv ====
/* Word-serial Montgomery multiplier
   Computes opa * opb * 2^-REG_SIZE mod prime, one RADIX digit of opb per cycle */

`timescale 1ns/1ps
`include "fau_consts.svh"

module fau_mont_mult #(
    parameter int REG_SIZE = `FAU_REG_SIZE,
    parameter int RADIX    = `FAU_RADIX
) (
    input logic      clk,
    input logic      reset_i,
    fau_mult_if.unit mult
);

    localparam int NUM_WORDS = REG_SIZE / RADIX;
    // Accumulator one digit wider than the operand
    localparam int ACC_W     = REG_SIZE + RADIX;
    // Headroom for acc + a*b_i + q*p
    localparam int SUM_W     = ACC_W + 2;
    localparam int CNT_W     = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FINISH
    } state_t;

    state_t              state_q;
    logic [CNT_W-1:0]    cnt_q;
    logic [REG_SIZE-1:0] res_q;

    // Captured operands, opb shifts down one digit per cycle
    logic [REG_SIZE-1:0] opa_q;
    logic [REG_SIZE-1:0] opb_q;
    logic [REG_SIZE-1:0] prime_q;
    logic [RADIX-1:0]    mu_q;
    logic [ACC_W-1:0]    acc_q;

    logic                ready;
    logic                start_ok;
    logic                last_digit;
    logic                fin_sub;
    logic [ACC_W-1:0]    prod_ab;
    logic [ACC_W-1:0]    prod_qp;
    logic [RADIX-1:0]    q_digit;
    logic [SUM_W-1:0]    sum_ab;
    logic [SUM_W-1:0]    sum_abq;
    logic [ACC_W-1:0]    acc_next;
    logic [REG_SIZE:0]   acc_lo;
    logic [REG_SIZE:0]   acc_diff;
    logic [REG_SIZE:0]   acc_red;

    // ----------------------------------------
    // Digit step
    // ----------------------------------------

    // acc + opa * b_i
    assign prod_ab = {{RADIX{1'b0}}, opa_q} * {{REG_SIZE{1'b0}}, opb_q[RADIX-1:0]};
    assign sum_ab  = {2'b00, acc_q} + {2'b00, prod_ab};

    // Quotient digit clears the low digit of the sum
    // Only the low RADIX bits of the product matter
    assign q_digit = sum_ab[RADIX-1:0] * mu_q;
    assign prod_qp = {{RADIX{1'b0}}, prime_q} * {{REG_SIZE{1'b0}}, q_digit};
    assign sum_abq = sum_ab + {2'b00, prod_qp};

    // Low digit is zero here, drop it
    assign acc_next = ACC_W'(sum_abq >> RADIX);

    // ----------------------------------------
    // Final conditional subtraction
    // ----------------------------------------

    // Accumulator stays below 2*prime, one subtraction is enough
    assign acc_lo   = acc_q[REG_SIZE:0];
    assign acc_diff = acc_lo - {1'b0, prime_q};
    assign acc_red  = (acc_lo >= {1'b0, prime_q}) ? acc_diff : acc_lo;

    // ----------------------------------------
    // Control
    // ----------------------------------------

    assign ready      = (state_q == IDLE);
    assign start_ok   = mult.start & ready;
    assign last_digit = (cnt_q == CNT_W'(NUM_WORDS - 1));
    // First FINISH cycle reduces, second one registers the result
    assign fin_sub    = (state_q == FINISH) && (cnt_q == '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            res_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_ok) begin
                        state_q <= RUN;
                        cnt_q   <= '0;
                    end
                end
                RUN: begin
                    cnt_q <= cnt_q + CNT_W'(1);
                    if (last_digit) begin
                        state_q <= FINISH;
                        cnt_q   <= '0;
                    end
                end
                FINISH: begin
                    cnt_q <= cnt_q + CNT_W'(1);
                    if (!fin_sub) begin
                        res_q   <= acc_q[REG_SIZE-1:0];
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Datapath registers
    always_ff @(posedge clk) begin
        if (start_ok) begin
            opa_q   <= mult.opa;
            opb_q   <= mult.opb;
            prime_q <= mult.prime;
            mu_q    <= mult.mu;
            acc_q   <= '0;
        end else if (state_q == RUN) begin
            acc_q <= acc_next;
            opb_q <= opb_q >> RADIX;
        end else if (fin_sub) begin
            acc_q <= ACC_W'(acc_red);
        end
    end

    assign mult.res   = res_q;
    assign mult.ready = ready;

endmodule

// ==== hdl/fau_pkg.sv ====
/* Field arithmetic unit types
   Operand and digit types shared by the RTL and the testbench */

`include "fau_consts.svh"

package fau_pkg;

    // ----------------------------------------
    // Data types
    // ----------------------------------------

    // One field element or the modulus
    typedef logic [`FAU_REG_SIZE-1:0] operand_t;

    // One multiplier digit
    // Also the width of the Montgomery constant mu
    typedef logic [`FAU_RADIX-1:0] digit_t;

endpackage

// ==== hdl/fau_top.sv ====
/* Finite field arithmetic unit top
   Montgomery multiplier and modular adder/subtractor behind registered controls */

`timescale 1ns/1ps

module fau_top (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              sub_i,
    input  logic              red_i,
    input  logic              mult_start_i,
    input  fau_pkg::operand_t prime_i,
    input  fau_pkg::operand_t opa_i,
    input  fau_pkg::operand_t opb_i,
    input  fau_pkg::digit_t   mult_mu_i,
    output fau_pkg::operand_t add_res_o,
    output fau_pkg::operand_t mult_res_o,
    output logic              ready_o
);

    // Registered control levels
    logic sub_q;
    logic red_q;
    // Start level and its delayed copy
    logic start_q;
    logic start_dly_q;
    logic start_pulse;

    fau_mult_if   mult_bus ();
    fau_addsub_if addsub_bus ();

    // ----------------------------------------
    // Control registers
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (reset_i) begin
            sub_q       <= 1'b0;
            red_q       <= 1'b0;
            start_q     <= 1'b0;
            start_dly_q <= 1'b0;
        end else begin
            sub_q       <= sub_i;
            red_q       <= red_i;
            start_q     <= mult_start_i;
            start_dly_q <= start_q;
        end
    end

    // One pulse per rising edge of the start level
    assign start_pulse = start_q & ~start_dly_q;

    // ----------------------------------------
    // Multiplier
    // ----------------------------------------

    assign mult_bus.start = start_pulse;
    assign mult_bus.opa   = opa_i;
    assign mult_bus.opb   = opb_i;
    assign mult_bus.prime = prime_i;
    assign mult_bus.mu    = mult_mu_i;

    fau_mont_mult u_mont_mult (
        .clk    (clk),
        .reset_i(reset_i),
        .mult   (mult_bus.unit)
    );

    // Adder/subtractor
    // Operands go straight in, sub and red take the register stage
    assign addsub_bus.sub   = sub_q;
    assign addsub_bus.red   = red_q;
    assign addsub_bus.opa   = opa_i;
    assign addsub_bus.opb   = opb_i;
    assign addsub_bus.prime = prime_i;

    fau_add_sub_mod u_add_sub_mod (
        .clk    (clk),
        .reset_i(reset_i),
        .addsub (addsub_bus.unit)
    );

    assign add_res_o  = addsub_bus.res;
    assign mult_res_o = mult_bus.res;
    assign ready_o    = mult_bus.ready;

endmodule

// ==== include/fau_consts.svh ====
/* Field arithmetic unit widths
   Operand size, multiplier digit size and digits per operand */

`ifndef FAU_CONSTS_SVH
`define FAU_CONSTS_SVH

// Operand and modulus width in bits
`define FAU_REG_SIZE 64

// Digit consumed per multiplier iteration
// Must divide FAU_REG_SIZE
`define FAU_RADIX 16

// Digits per operand, also the multiplier iteration count
`define FAU_NUM_WORDS (`FAU_REG_SIZE / `FAU_RADIX)

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Build the field arithmetic unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module fau_tb -f compile.f -Mdir obj_dir -o fau_sim

./obj_dir/fau_sim

// ==== test/fau_sva.sv ====
/* Multiplier handshake assertions
   Bound into the field arithmetic unit top */

`timescale 1ns/1ps

module fau_sva (
    input logic              clk,
    input logic              reset_i,
    input logic              start_pulse,
    input logic              ready_o,
    input fau_pkg::operand_t mult_res_o,
    input fau_pkg::operand_t prime_i
);

    // Multiplier idle once reset is seen
    ready_after_reset: assert property (@(posedge clk) reset_i |=> ready_o)
        else $error("ready_o low in the cycle after reset");

    // Accepted start makes the unit busy on the next edge
    busy_after_start: assert property (@(posedge clk) disable iff (reset_i)
        (start_pulse && ready_o) |=> !ready_o)
        else $error("ready_o still high one cycle after the start pulse");

    // Finished product fully reduced
    res_below_prime: assert property (@(posedge clk) disable iff (reset_i)
        $rose(ready_o) |-> (mult_res_o < prime_i))
        else $error("mult_res_o not below prime_i when ready_o rose");

endmodule

bind fau_top fau_sva u_sva (
    .clk        (clk),
    .reset_i    (reset_i),
    .start_pulse(start_pulse),
    .ready_o    (ready_o),
    .mult_res_o (mult_res_o),
    .prime_i    (prime_i)
);

// ==== test/fau_tb.sv ====
/* Field arithmetic unit testbench
   Modular add/sub, wrapping add/sub and Montgomery multiply against reference models */

`timescale 1ns/1ps
`include "fau_consts.svh"

module fau_tb;

    localparam int REG_SIZE   = `FAU_REG_SIZE;
    localparam int NUM_WORDS  = `FAU_NUM_WORDS;
    localparam int N_ADD_RED  = 40;
    localparam int N_ADD_WRAP = 20;
    localparam int N_MULT     = 20;
    // Corner operations and the held-start sequence
    localparam int N_EXTRA    = 16;
    localparam int MAX_CYCLES = (N_ADD_RED + N_ADD_WRAP + N_MULT + N_EXTRA) * 40 + 200;

    // Largest 64-bit prime (2^64 - 59)
    localparam fau_pkg::operand_t PRIME   = 64'hFFFF_FFFF_FFFF_FFC5;
    localparam fau_pkg::operand_t ONE     = 1;
    localparam fau_pkg::operand_t TOP_BIT = ONE << (REG_SIZE - 1);

    logic              clk;
    logic              reset_i;
    logic              sub_i;
    logic              red_i;
    logic              mult_start_i;
    fau_pkg::operand_t prime_i;
    fau_pkg::operand_t opa_i;
    fau_pkg::operand_t opb_i;
    fau_pkg::digit_t   mult_mu_i;
    fau_pkg::operand_t add_res_o;
    fau_pkg::operand_t mult_res_o;
    logic              ready_o;

    integer            seed;
    int                cycle_cnt = 0;
    // Expected values for the compare process
    fau_pkg::operand_t add_exp;
    logic              add_chk;
    fau_pkg::operand_t mult_exp;
    int                mult_issued;
    int                mult_done;
    logic              ready_prev;

    fau_top DUT (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Run length guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    // ----------------------------------------
    // Reference models
    // ----------------------------------------

    // Newton iteration for -p^-1 mod 2^RADIX
    // Start value p is exact to 3 bits
    function automatic fau_pkg::digit_t calc_mu(input fau_pkg::operand_t p);
        fau_pkg::operand_t inv;
        inv = p;
        for (int i = 0; i < 6; i++) begin
            inv = inv * (fau_pkg::operand_t'(2) - p * inv);
        end
        return fau_pkg::digit_t'(-inv);
    endfunction

    // Bit-serial a * b * 2^-REG_SIZE mod p
    function automatic fau_pkg::operand_t mont_ref(input fau_pkg::operand_t a,
                                                   input fau_pkg::operand_t b,
                                                   input fau_pkg::operand_t p);
        logic [REG_SIZE+1:0] t;
        t = '0;
        for (int i = 0; i < REG_SIZE; i++) begin
            if (a[i]) begin
                t = t + {2'b00, b};
            end
            if (t[0]) begin
                t = t + {2'b00, p};
            end
            t = t >> 1;
        end
        if (t >= {2'b00, p}) begin
            t = t - {2'b00, p};
        end
        return t[REG_SIZE-1:0];
    endfunction

    // Sum or difference reduced mod p or wrapping
    function automatic fau_pkg::operand_t addsub_ref(input logic sub, input logic red,
                                                     input fau_pkg::operand_t a,
                                                     input fau_pkg::operand_t b,
                                                     input fau_pkg::operand_t p);
        logic [REG_SIZE:0] full;
        if (sub) begin
            full = {1'b0, a} - {1'b0, b};
            if (red && (a < b)) begin
                full = full + {1'b0, p};
            end
        end else begin
            full = {1'b0, a} + {1'b0, b};
            if (red && (full >= {1'b0, p})) begin
                full = full - {1'b0, p};
            end
        end
        return full[REG_SIZE-1:0];
    endfunction

    // ----------------------------------------
    // Compare
    // ----------------------------------------

    task automatic check(input fau_pkg::operand_t got, input fau_pkg::operand_t expected,
                         input string what);
        if (got !== expected) begin
            $display("mismatch at %0d ns: %s, got %h, expected %h",
                     $time, what, got, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "result check failed");
        end
    endtask

    // Outputs sampled mid-cycle away from the drive edge
    always @(negedge clk) begin
        ready_prev <= ready_o;
        if (reset_i) begin
            mult_done <= 0;
        end else begin
            if (add_chk) begin
                check(add_res_o, add_exp, "add_res_o");
            end
            if (ready_o && !ready_prev) begin
                if (mult_done == mult_issued) begin
                    $display("ready_o rose with no multiply outstanding");
                    $display("TEST RESULT: FAIL");
                    $fatal(1, "unexpected multiply completion");
                end else begin
                    check(mult_res_o, mult_exp, "mult_res_o");
                    mult_done <= mult_done + 1;
                end
            end
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic rand_operand(output fau_pkg::operand_t v);
        v = {$random(seed), $random(seed)};
        v = v % PRIME;
    endtask

    // Inputs held for three cycles and checked in the third
    task automatic run_addsub(input logic sub, input logic red,
                              input fau_pkg::operand_t a, input fau_pkg::operand_t b);
        sub_i   = sub;
        red_i   = red;
        opa_i   = a;
        opb_i   = b;
        add_exp = addsub_ref(sub, red, a, b, PRIME);
        next_cycle();
        next_cycle();
        add_chk = 1'b1;
        next_cycle();
        add_chk = 1'b0;
    endtask

    // Start level left high on return
    task automatic run_mult(input fau_pkg::operand_t a, input fau_pkg::operand_t b);
        int cycles;
        opa_i        = a;
        opb_i        = b;
        mult_exp     = mont_ref(a, b, PRIME);
        mult_issued  = mult_issued + 1;
        mult_start_i = 1'b1;
        next_cycle();
        check(fau_pkg::operand_t'(ready_o), ONE, "ready_o before the start pulse");
        next_cycle();
        check(fau_pkg::operand_t'(ready_o), '0, "ready_o after the start pulse");
        cycles = 2;
        while (!ready_o) begin
            next_cycle();
            cycles++;
        end
        // Two edges to the pulse and one per digit plus two
        check(fau_pkg::operand_t'(cycles), fau_pkg::operand_t'(NUM_WORDS + 4),
              "cycles from start rise to ready_o");
        wait (mult_done == mult_issued);
        next_cycle();
    endtask

    // One low cycle so the next rise makes a pulse
    task automatic drop_start();
        mult_start_i = 1'b0;
        next_cycle();
    endtask

    initial begin
        fau_pkg::operand_t a;
        fau_pkg::operand_t b;
        int                r;
        seed         = 32'h293283d5;
        reset_i      = 1'b1;
        sub_i        = 1'b0;
        red_i        = 1'b0;
        mult_start_i = 1'b0;
        prime_i      = PRIME;
        opa_i        = '0;
        opb_i        = '0;
        mult_mu_i    = calc_mu(PRIME);
        add_exp      = '0;
        add_chk      = 1'b0;
        mult_exp     = '0;
        mult_issued  = 0;
        repeat (3) @(posedge clk);
        #1;
        reset_i = 1'b0;

        // Reset state
        check(fau_pkg::operand_t'(ready_o), ONE, "ready_o after reset");
        check(mult_res_o, '0, "mult_res_o after reset");
        check(add_res_o, '0, "add_res_o after reset");

        // Modular corners with equal operands and values near prime
        for (int s = 0; s < 2; s++) begin
            run_addsub(s[0], 1'b1, PRIME - ONE, PRIME - ONE);
            run_addsub(s[0], 1'b1, PRIME - ONE, ONE);
            run_addsub(s[0], 1'b1, '0, PRIME - ONE);
            run_addsub(s[0], 1'b1, 64'h1234_5678_9ABC_DEF0, 64'h1234_5678_9ABC_DEF0);
        end
        for (int i = 0; i < N_ADD_RED; i++) begin
            rand_operand(a);
            rand_operand(b);
            r = $random(seed);
            if (i % 4 == 0) begin
                a = PRIME - ONE - (a & 64'hFF);
            end
            run_addsub(r[0], 1'b1, a, b);
        end

        // Wrapping results with top bits set so most sums overflow
        run_addsub(1'b0, 1'b0, '1, ONE);
        run_addsub(1'b1, 1'b0, '0, ONE);
        for (int i = 0; i < N_ADD_WRAP; i++) begin
            rand_operand(a);
            rand_operand(b);
            r = $random(seed);
            run_addsub(r[0], 1'b0, a | TOP_BIT, b | TOP_BIT);
        end

        // Multiplier corners then random pairs
        run_mult('0, 64'h0123_4567_89AB_CDEF);
        drop_start();
        run_mult(ONE, ONE);
        drop_start();
        run_mult(PRIME - ONE, PRIME - ONE);
        drop_start();
        run_mult(ONE, PRIME - ONE);
        drop_start();
        for (int i = 0; i < N_MULT; i++) begin
            rand_operand(a);
            rand_operand(b);
            run_mult(a, b);
            drop_start();
        end

        // Start held high across three operation lengths
        rand_operand(a);
        rand_operand(b);
        run_mult(a, b);
        repeat (3 * (NUM_WORDS + 4)) begin
            rand_operand(opa_i);
            rand_operand(opb_i);
            next_cycle();
            check(fau_pkg::operand_t'(ready_o), ONE, "ready_o with start held high");
            check(mult_res_o, mult_exp, "mult_res_o with start held high");
        end
        drop_start();

        // Second rise while busy is ignored
        rand_operand(a);
        rand_operand(b);
        opa_i        = a;
        opb_i        = b;
        mult_exp     = mont_ref(a, b, PRIME);
        mult_issued  = mult_issued + 1;
        mult_start_i = 1'b1;
        repeat (3) next_cycle();
        mult_start_i = 1'b0;
        rand_operand(opa_i);
        rand_operand(opb_i);
        next_cycle();
        mult_start_i = 1'b1;
        next_cycle();
        mult_start_i = 1'b0;
        wait (mult_done == mult_issued);
        next_cycle();
        repeat (NUM_WORDS + 4) begin
            next_cycle();
            check(fau_pkg::operand_t'(ready_o), ONE, "ready_o after ignored start");
            check(mult_res_o, mult_exp, "mult_res_o after ignored start");
        end

        next_cycle();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
